/* sim.f */
verilog/ppu_pkg.sv
verilog/ppu_regs.sv
verilog/ppu_render.sv
verilog/ppu_palette.sv
verilog/ppu_top.sv
tests/tb_vram.sv
tests/tb_ppu.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, and decide from the log
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_ppu -o tb_ppu_sim \
    && ./obj_dir/tb_ppu_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qs "^TEST PASS$" sim.log && echo "result: passed" || { echo "result: failed"; exit 1; }

/* tests/tb_ppu.sv */
`timescale 1ns/1ps

module tb_ppu import ppu_pkg::*; ();

    localparam int FRAME_CYCLES = DOTS_PER_LINE * LINES_PER_FRAME + 400;
    localparam int VBL_CYCLES   = DOTS_PER_LINE * (LINES_PER_FRAME - VBLANK_LINE - 1);

    typedef struct packed {
        reg_addr_e   addr;
        logic        rw;
        logic [7:0]  wdata;
        logic [7:0]  exp;     // expected read byte
        logic [7:0]  mask;    // read bits that are compared
        logic        chk;
        logic        pulse;   // vram write expected
        logic [13:0] waddr;
    } step_t;

    logic        clk;
    logic        rst;
    cpu_bus_t    cpu;
    logic [7:0]  cpu_rdata;
    logic [13:0] vram_addr;
    logic [7:0]  vram_rdata;
    logic [7:0]  vram_wdata;
    logic        vram_wr;
    logic [7:0]  px_data;
    logic        px_valid;
    logic        vblank;
    logic        nmi;

    // testbench side model of the cpu view
    step_t       steps [$];
    logic [7:0]  vram_copy [16384];
    logic [5:0]  pal_model [32];
    logic [13:0] m_addr;
    logic [5:0]  m_hi;
    logic        m_w;
    logic        m_inc32;
    logic [7:0]  m_buf;
    logic [31:0] seed;

    ppu_top #(
        .SKIP_ODD_DOT (1'b1)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .cpu_i        (cpu),
        .cpu_rdata_o  (cpu_rdata),
        .vram_addr_o  (vram_addr),
        .vram_rdata_i (vram_rdata),
        .vram_wdata_o (vram_wdata),
        .vram_wr_o    (vram_wr),
        .px_data_o    (px_data),
        .px_valid_o   (px_valid),
        .vblank_o     (vblank),
        .nmi_o        (nmi)
    );

    tb_vram vram0 (
        .clk     (clk),
        .addr_i  (vram_addr),
        .wr_i    (vram_wr),
        .wdata_i (vram_wdata),
        .rdata_o (vram_rdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] vram_init_byte(input logic [13:0] a);
        if (a < 14'h2000) begin
            return a[3] ? 8'h00 : 8'hff;
        end
        if (a[13:12] == 2'b10 && a[9:6] == 4'hf) begin
            return 8'h55;
        end
        return a[7:0];
    endfunction

    // sprite backdrops share the background entries
    function automatic logic [4:0] pal_fold(input logic [4:0] a);
        if (a == 5'h10 || a == 5'h14 || a == 5'h18 || a == 5'h1c) begin
            return a & 5'h0f;
        end
        return a;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic add_write(input reg_addr_e a, input logic [7:0] d);
        step_t s;
        s       = '0;
        s.addr  = a;
        s.wdata = d;
        s.waddr = m_addr;   // address before the increment
        case (a)
            PPUCTRL: m_inc32 = d[2];
            PPUSCROLL: m_w = ~m_w;
            PPUADDR: begin
                if (!m_w) begin
                    m_hi = d[5:0];
                end else begin
                    m_addr = {m_hi, d};
                end
                m_w = ~m_w;
            end
            PPUDATA: begin
                if (m_addr >= 14'h3f00) begin
                    pal_model[pal_fold(m_addr[4:0])] = d[5:0];
                end else begin
                    vram_copy[m_addr] = d;
                    s.pulse = 1'b1;
                end
                m_addr = m_addr + (m_inc32 ? 14'd32 : 14'd1);
            end
            default: begin
            end
        endcase
        steps.push_back(s);
    endtask

    task automatic add_data_read(input logic chk);
        step_t s;
        s      = '0;
        s.addr = PPUDATA;
        s.rw   = 1'b1;
        s.mask = 8'hff;
        s.chk  = chk;
        if (m_addr >= 14'h3f00) begin
            s.exp = {2'b00, pal_model[pal_fold(m_addr[4:0])]};  // no buffering
        end else begin
            s.exp = m_buf;
            m_buf = vram_copy[m_addr];
        end
        m_addr = m_addr + (m_inc32 ? 14'd32 : 14'd1);
        steps.push_back(s);
    endtask

    task automatic add_status(input logic flag);
        step_t s;
        s      = '0;
        s.addr = PPUSTATUS;
        s.rw   = 1'b1;
        s.exp  = {flag, 7'h00};
        s.mask = 8'he0;     // vblank bit plus the two zero bits
        s.chk  = 1'b1;
        m_w    = 1'b0;
        steps.push_back(s);
    endtask

    // cs high for two clocks, low for two
    task automatic run_steps(input int first);
        step_t s;
        for (int i = first; i < steps.size(); i++) begin
            s         = steps[i];
            cpu.cs    = 1'b1;
            cpu.rw    = s.rw;
            cpu.addr  = s.addr;
            cpu.wdata = s.wdata;
            @(negedge clk);
            assert (vram_wr == s.pulse) else report_mismatch("vram_wr_o", vram_wr, s.pulse);
            if (s.pulse) begin
                assert (vram_addr == s.waddr)
                    else report_mismatch("vram_addr_o", vram_addr, s.waddr);
                assert (vram_wdata == s.wdata)
                    else report_mismatch("vram_wdata_o", vram_wdata, s.wdata);
            end
            @(negedge clk);
            assert (!vram_wr) else report_mismatch("vram_wr_o", vram_wr, 1'b0);
            if (s.chk) begin
                assert ((cpu_rdata & s.mask) == (s.exp & s.mask))
                    else report_mismatch("cpu_rdata_o", cpu_rdata, s.exp);
            end
            cpu.cs = 1'b0;
            @(negedge clk);
            @(negedge clk);
        end
    endtask

    task automatic wait_vblank_rise();
        int n;
        n = 0;
        while (vblank) begin
            @(negedge clk);
            n++;
            assert (n < FRAME_CYCLES) else stop_run("timeout waiting for vblank to end");
        end
        while (!vblank) begin
            @(negedge clk);
            n++;
            assert (n < FRAME_CYCLES) else stop_run("timeout waiting for vblank to start");
        end
    endtask

    // scans from one vblank start to the next
    task automatic check_frame(input logic [7:0] exp);
        int n;
        int run;
        int lines;
        int hi;
        n     = 0;
        run   = 0;
        lines = 0;
        hi    = 1;      // the cycle where the rise was seen
        wait_vblank_rise();
        while (!(vblank && lines > 0)) begin
            @(negedge clk);
            n++;
            assert (n < FRAME_CYCLES) else stop_run("timeout while scanning a frame");
            if (vblank && lines == 0) begin
                hi++;
            end
            if (px_valid) begin
                assert (px_data == exp) else report_mismatch("px_data_o", px_data, exp);
                run++;
            end else if (run != 0) begin
                assert (run == 256) else report_mismatch("px_valid_o run length", run, 256);
                lines++;
                run = 0;
            end
        end
        assert (lines == 240) else report_mismatch("px_valid_o line count", lines, 240);
        assert (hi == VBL_CYCLES)
            else report_mismatch("vblank_o high cycles", hi, VBL_CYCLES);
    endtask

    initial begin
        int first;
        clk     = 1'b0;
        rst     = 1'b1;
        cpu     = '0;
        seed    = 32'h1d;
        m_addr  = '0;
        m_hi    = '0;
        m_w     = 1'b0;
        m_inc32 = 1'b0;
        m_buf   = '0;
        for (int a = 0; a < 16384; a++) begin
            vram_copy[a] = vram_init_byte(14'(a));
        end
        for (int i = 0; i < 32; i++) begin
            pal_model[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // data writes, step 1 then step 32
        first = steps.size();
        add_write(PPUCTRL, 8'h00);
        add_write(PPUADDR, 8'h21);
        add_write(PPUADDR, 8'h00);
        repeat (4) begin
            seed = xorshift32(seed);
            add_write(PPUDATA, seed[7:0]);
        end
        add_write(PPUCTRL, 8'h04);
        repeat (4) begin
            seed = xorshift32(seed);
            add_write(PPUDATA, seed[7:0]);
        end

        // buffered reads, first one primes the buffer
        add_write(PPUCTRL, 8'h00);
        add_write(PPUADDR, 8'h22);
        add_write(PPUADDR, 8'h10);
        add_data_read(1'b0);
        add_write(PPUADDR, 8'h21);
        add_write(PPUADDR, 8'h02);
        repeat (5) add_data_read(1'b1);

        // palette entries 05 and 10, then 00 through the mirror
        seed = xorshift32(seed);
        add_write(PPUADDR, 8'h3f);
        add_write(PPUADDR, 8'h05);
        add_write(PPUDATA, seed[7:0]);
        seed = xorshift32(seed);
        add_write(PPUADDR, 8'h3f);
        add_write(PPUADDR, 8'h10);
        add_write(PPUDATA, seed[7:0]);
        add_write(PPUADDR, 8'h3f);
        add_write(PPUADDR, 8'h05);
        add_data_read(1'b1);
        add_write(PPUADDR, 8'h3f);
        add_write(PPUADDR, 8'h10);
        add_data_read(1'b1);
        add_write(PPUADDR, 8'h3f);
        add_write(PPUADDR, 8'h00);
        add_data_read(1'b1);
        add_write(PPUCTRL, 8'h80);  // nmi on
        run_steps(first);

        wait_vblank_rise();
        assert (nmi) else report_mismatch("nmi_o", nmi, 1'b1);
        first = steps.size();
        add_write(PPUADDR, 8'h23);  // toggle left half way
        add_status(1'b1);
        run_steps(first);
        assert (!nmi) else report_mismatch("nmi_o", nmi, 1'b0);

        // toggle cleared, so 21 is the high byte
        first = steps.size();
        add_status(1'b0);
        add_write(PPUADDR, 8'h21);
        add_write(PPUADDR, 8'h40);
        add_data_read(1'b0);
        add_data_read(1'b1);
        add_write(PPUADDR, 8'h20);
        add_write(PPUADDR, 8'h00);
        add_write(PPUMASK, 8'h0a);  // bg_en, bg_left
        run_steps(first);
        check_frame({2'b00, pal_model[5]});

        first = steps.size();
        add_write(PPUMASK, 8'h00);
        add_write(PPUADDR, 8'h20);
        add_write(PPUADDR, 8'h00);
        run_steps(first);
        check_frame({2'b00, pal_model[0]});

        $display("TEST PASS");
        $finish;
    end

endmodule

/* tests/tb_vram.sv */
`timescale 1ns/1ps

// behavioral 16 KB vram, asynchronous read, write on the clock edge
module tb_vram (
    input  logic        clk,
    input  logic [13:0] addr_i,
    input  logic        wr_i,
    input  logic [7:0]  wdata_i,
    output logic [7:0]  rdata_o
);

    logic [7:0] mem [16384];

    function automatic logic [7:0] fill_byte(input logic [13:0] a);
        if (a < 14'h2000) begin
            return a[3] ? 8'h00 : 8'hff;    // plane 1 clear, plane 0 set
        end
        if (a[13:12] == 2'b10 && a[9:6] == 4'hf) begin
            return 8'h55;                   // attribute tables
        end
        return a[7:0];
    endfunction

    initial begin
        for (int a = 0; a < 16384; a++) begin
            mem[a] = fill_byte(14'(a));
        end
    end

    always @(posedge clk) begin
        if (wr_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    assign rdata_o = mem[addr_i];

endmodule

/* verilog/ppu_top.sv */
`timescale 1ns/1ps

module ppu_top import ppu_pkg::*; #(
    parameter bit SKIP_ODD_DOT = 1'b1
) (
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    cpu_i,
    output logic [7:0]  cpu_rdata_o,
    output logic [13:0] vram_addr_o,
    input  logic [7:0]  vram_rdata_i,
    output logic [7:0]  vram_wdata_o,
    output logic        vram_wr_o,
    output logic [7:0]  px_data_o,
    output logic        px_valid_o,
    output logic        vblank_o,
    output logic        nmi_o
);

    loopy_t       v;
    logic [2:0]   fine_x;
    ppu_ctrl_t    ctrl;
    ppu_mask_t    mask;
    fetch_e       fetch;
    logic [13:0]  fetch_addr;
    scroll_step_t step;
    logic [4:0]   palette_idx;
    logic         px_en;
    logic         px_en_q;
    logic         vblank;
    logic [7:0]   pal_rdata;
    logic         pal_wr;
    logic         pal_sel;
    logic [4:0]   pal_addr;

    ppu_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .cpu_i        (cpu_i),
        .cpu_rdata_o  (cpu_rdata_o),
        .vram_rdata_i (vram_rdata_i),
        .vram_addr_o  (vram_addr_o),
        .vram_wdata_o (vram_wdata_o),
        .vram_wr_o    (vram_wr_o),
        .pal_rdata_i  (pal_rdata),
        .pal_wr_o     (pal_wr),
        .pal_sel_o    (pal_sel),
        .fetch_i      (fetch),
        .fetch_addr_i (fetch_addr),
        .step_i       (step),
        .vblank_i     (vblank),
        .v_o          (v),
        .fine_x_o     (fine_x),
        .ctrl_o       (ctrl),
        .mask_o       (mask),
        .nmi_o        (nmi_o)
    );

    ppu_render #(
        .SKIP_ODD_DOT (SKIP_ODD_DOT)
    ) u_render (
        .clk           (clk),
        .rst           (rst),
        .v_i           (v),
        .fine_x_i      (fine_x),
        .ctrl_i        (ctrl),
        .mask_i        (mask),
        .vram_rdata_i  (vram_rdata_i),
        .fetch_o       (fetch),
        .fetch_addr_o  (fetch_addr),
        .step_o        (step),
        .palette_idx_o (palette_idx),
        .px_en_o       (px_en),
        .vblank_o      (vblank)
    );

    // renderer drives the palette unless the cpu is pointed at it
    assign pal_addr = (px_en && !pal_sel) ? palette_idx : v.addr.vaddr[4:0];

    ppu_palette u_palette (
        .clk     (clk),
        .addr_i  (pal_addr),
        .wr_i    (pal_wr),
        .wdata_i (vram_wdata_o),
        .rdata_o (pal_rdata)
    );

    // palette read takes one clock
    always_ff @(posedge clk) begin
        if (rst) begin
            px_en_q <= 1'b0;
        end else begin
            px_en_q <= px_en;
        end
    end

    assign px_valid_o = px_en_q;
    assign px_data_o  = px_en_q ? pal_rdata : PIXEL_BLACK;
    assign vblank_o   = vblank;

endmodule

/* verilog/ppu_palette.sv */
`timescale 1ns/1ps

module ppu_palette (
    input  logic       clk,
    input  logic [4:0] addr_i,
    input  logic       wr_i,
    input  logic [7:0] wdata_i,
    output logic [7:0] rdata_o
);

    logic [5:0] mem [32];
    logic [5:0] rdata_q;
    logic [4:0] addr_f;

    // sprite backdrop entries 10/14/18/1c alias the bg ones
    assign addr_f = (addr_i[1:0] == 2'b00) ? {1'b0, addr_i[3:0]} : addr_i;

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[addr_f] <= wdata_i[5:0];
        end
        rdata_q <= mem[addr_f];
    end

    assign rdata_o = {2'b00, rdata_q};  // only 64 colors

endmodule

/* verilog/ppu_render.sv */
`timescale 1ns/1ps

module ppu_render import ppu_pkg::*; #(
    parameter bit SKIP_ODD_DOT = 1'b1
) (
    input  logic         clk,
    input  logic         rst,
    input  loopy_t       v_i,
    input  logic [2:0]   fine_x_i,
    input  ppu_ctrl_t    ctrl_i,
    input  ppu_mask_t    mask_i,
    input  logic [7:0]   vram_rdata_i,
    output fetch_e       fetch_o,
    output logic [13:0]  fetch_addr_o,
    output scroll_step_t step_o,
    output logic [4:0]   palette_idx_o,
    output logic         px_en_o,
    output logic         vblank_o
);

    localparam logic [8:0] LAST_DOT  = 9'(DOTS_PER_LINE - 1);
    localparam logic [8:0] LAST_LINE = 9'(LINES_PER_FRAME - 1);
    localparam logic [8:0] VBL_LINE  = 9'(VBLANK_LINE);

    logic [8:0]  dot_q;
    logic [8:0]  line_q;
    logic        odd_q;
    logic        vblank_q;
    logic        skip;
    logic        render_line;
    logic        visible;
    logic        fetch_win;
    logic [7:0]  nt_byte_q;
    logic [1:0]  attr_q;
    logic [7:0]  pt_lo_q;
    logic [1:0]  at_bits;
    logic [13:0] nt_addr;
    logic [13:0] at_addr;
    logic [13:0] pt_addr;
    logic [15:0] pt_lo_sh;
    logic [15:0] pt_hi_sh;
    logic [15:0] at_lo_sh;
    logic [15:0] at_hi_sh;
    logic [3:0]  bit_sel;
    logic [1:0]  pix;
    logic [1:0]  pal;

    // one dot short on odd frames while rendering
    assign skip = SKIP_ODD_DOT && odd_q && mask_i.bg_en &&
                  (line_q == LAST_LINE) && (dot_q == LAST_DOT - 9'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            dot_q    <= '0;
            line_q   <= '0;
            odd_q    <= 1'b0;
            vblank_q <= 1'b0;
        end else begin
            if (dot_q == LAST_DOT || skip) begin
                dot_q <= '0;
                if (line_q == LAST_LINE) begin
                    line_q <= '0;
                    odd_q  <= ~odd_q;
                end else begin
                    line_q <= line_q + 9'd1;
                end
            end else begin
                dot_q <= dot_q + 9'd1;
            end

            if (line_q == VBL_LINE && dot_q == 9'd0) begin
                vblank_q <= 1'b1;   // high from dot 1
            end else if (line_q == LAST_LINE && dot_q == 9'd0) begin
                vblank_q <= 1'b0;
            end
        end
    end

    assign render_line = (line_q < VBL_LINE - 9'd1) || (line_q == LAST_LINE);
    assign visible     = (line_q < VBL_LINE - 9'd1) && (dot_q >= 9'd1) && (dot_q <= 9'd256);
    assign fetch_win   = mask_i.bg_en && render_line &&
                         (((dot_q >= 9'd1) && (dot_q <= 9'd256)) ||
                          ((dot_q >= 9'd321) && (dot_q <= 9'd336)));

    assign nt_addr = {2'b10, v_i[11:0]};
    assign at_addr = {2'b10, v_i.scroll.nt, 4'b1111,
                      v_i.scroll.coarse_y[4:2], v_i.scroll.coarse_x[4:2]};
    // plane bit: phase 5 low, phase 0 high
    assign pt_addr = {1'b0, ctrl_i.bg_table, nt_byte_q, ~dot_q[2], v_i.scroll.fine_y};

    // quadrant inside the 32x32 attribute block
    always_comb begin
        case ({v_i.scroll.coarse_y[1], v_i.scroll.coarse_x[1]})
            2'b00:   at_bits = vram_rdata_i[1:0];
            2'b01:   at_bits = vram_rdata_i[3:2];
            2'b10:   at_bits = vram_rdata_i[5:4];
            default: at_bits = vram_rdata_i[7:6];
        endcase
    end

    always_comb begin
        fetch_o      = FETCH_NONE;
        fetch_addr_o = nt_addr;
        if (fetch_win) begin
            case (dot_q[2:0])
                3'd1: fetch_o = FETCH_NT;
                3'd3: begin
                    fetch_o      = FETCH_AT;
                    fetch_addr_o = at_addr;
                end
                3'd5, 3'd0: begin
                    fetch_o      = FETCH_PT;
                    fetch_addr_o = pt_addr;
                end
                default: fetch_o = FETCH_NONE;
            endcase
        end
    end

    // tile bytes and shifters, reload on every eighth dot
    always_ff @(posedge clk) begin
        if (fetch_win) begin
            case (dot_q[2:0])
                3'd1: nt_byte_q <= vram_rdata_i;
                3'd3: attr_q    <= at_bits;
                3'd5: pt_lo_q   <= vram_rdata_i;
                default: begin
                end
            endcase
            if (dot_q[2:0] == 3'd0) begin
                pt_lo_sh <= {pt_lo_sh[14:7], pt_lo_q};
                pt_hi_sh <= {pt_hi_sh[14:7], vram_rdata_i};  // high plane straight from bus
                at_lo_sh <= {at_lo_sh[14:7], {8{attr_q[0]}}};
                at_hi_sh <= {at_hi_sh[14:7], {8{attr_q[1]}}};
            end else begin
                pt_lo_sh <= {pt_lo_sh[14:0], 1'b0};
                pt_hi_sh <= {pt_hi_sh[14:0], 1'b0};
                at_lo_sh <= {at_lo_sh[14:0], 1'b0};
                at_hi_sh <= {at_hi_sh[14:0], 1'b0};
            end
        end
    end

    assign bit_sel = 4'd15 - {1'b0, fine_x_i};
    assign pix     = {pt_hi_sh[bit_sel], pt_lo_sh[bit_sel]};
    assign pal     = {at_hi_sh[bit_sel], at_lo_sh[bit_sel]};

    always_comb begin
        if (!mask_i.bg_en || (!mask_i.bg_left && dot_q <= 9'd8) || pix == 2'b00) begin
            palette_idx_o = 5'd0;   // backdrop
        end else begin
            palette_idx_o = {1'b0, pal, pix};
        end
    end

    always_comb begin
        step_o        = '0;
        step_o.inc_x  = fetch_win && (dot_q[2:0] == 3'd0);
        step_o.inc_y  = mask_i.bg_en && render_line && (dot_q == 9'd256);
        step_o.copy_x = mask_i.bg_en && render_line && (dot_q == 9'd257);
        step_o.copy_y = mask_i.bg_en && (line_q == LAST_LINE) &&
                        (dot_q >= 9'd280) && (dot_q <= 9'd304);
    end

    assign px_en_o  = visible;
    assign vblank_o = vblank_q;

endmodule

/* verilog/ppu_regs.sv */
`timescale 1ns/1ps

module ppu_regs import ppu_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  cpu_bus_t     cpu_i,
    output logic [7:0]   cpu_rdata_o,
    input  logic [7:0]   vram_rdata_i,
    output logic [13:0]  vram_addr_o,
    output logic [7:0]   vram_wdata_o,
    output logic         vram_wr_o,
    input  logic [7:0]   pal_rdata_i,
    output logic         pal_wr_o,
    output logic         pal_sel_o,
    input  fetch_e       fetch_i,
    input  logic [13:0]  fetch_addr_i,
    input  scroll_step_t step_i,
    input  logic         vblank_i,
    output loopy_t       v_o,
    output logic [2:0]   fine_x_o,
    output ppu_ctrl_t    ctrl_o,
    output ppu_mask_t    mask_o,
    output logic         nmi_o
);

    logic       cs_q;
    logic       rd_edge;
    logic       wr_edge;
    ppu_ctrl_t  ctrl_q;
    ppu_mask_t  mask_q;
    loopy_t     v_q;
    loopy_t     t_q;
    logic [2:0] fine_x_q;
    logic       w_q;          // first/second write toggle
    logic [7:0] io_latch_q;   // cpu data bus latch
    logic [7:0] rd_buf_q;     // PPUDATA read buffer
    logic       vram_wr_q;
    logic       pal_wr_q;
    logic       data_rd_q;
    logic       vblank_q;
    logic       vbl_occ_q;
    logic       vbl_rise;
    logic       vbl_flag;
    logic       in_pal;
    logic       inc_v;
    logic [14:0] v_inc;
    logic [7:0] status;

    // accesses start on the rising edge of cs
    assign rd_edge = cpu_i.cs & ~cs_q & cpu_i.rw;
    assign wr_edge = cpu_i.cs & ~cs_q & ~cpu_i.rw;

    assign in_pal   = (v_q.addr.vaddr[13:8] == 6'h3f);
    assign vbl_rise = vblank_i & ~vblank_q;
    assign vbl_flag = vbl_occ_q | vbl_rise;  // visible in the rising cycle already
    assign status   = {vbl_flag, 2'b00, io_latch_q[4:0]};

    // second cycle of a PPUDATA access steps v
    assign inc_v = vram_wr_q | pal_wr_q | data_rd_q;
    assign v_inc = v_q + (ctrl_q.inc32 ? 15'd32 : 15'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_q       <= 1'b0;
            ctrl_q     <= '0;
            mask_q     <= '0;
            v_q        <= '0;
            t_q        <= '0;
            fine_x_q   <= '0;
            w_q        <= 1'b0;
            io_latch_q <= '0;
            rd_buf_q   <= '0;
            vram_wr_q  <= 1'b0;
            pal_wr_q   <= 1'b0;
            data_rd_q  <= 1'b0;
            vblank_q   <= 1'b0;
            vbl_occ_q  <= 1'b0;
        end else begin
            cs_q      <= cpu_i.cs;
            vblank_q  <= vblank_i;
            vram_wr_q <= 1'b0;
            pal_wr_q  <= 1'b0;
            data_rd_q <= 1'b0;

            if (vbl_rise) begin
                vbl_occ_q <= 1'b1;
            end else if (vblank_q & ~vblank_i) begin
                vbl_occ_q <= 1'b0;
            end

            // scroll steps from the renderer
            if (step_i.inc_x) begin
                if (v_q.scroll.coarse_x == 5'd31) begin
                    v_q.scroll.nt[0] <= ~v_q.scroll.nt[0];  // next nametable across
                end
                v_q.scroll.coarse_x <= v_q.scroll.coarse_x + 5'd1;
            end
            if (step_i.inc_y) begin
                if (v_q.scroll.fine_y == 3'd7) begin
                    if (v_q.scroll.coarse_y == 5'd29) begin
                        v_q.scroll.coarse_y <= 5'd0;
                        v_q.scroll.nt[1]    <= ~v_q.scroll.nt[1];
                    end else if (v_q.scroll.coarse_y == 5'd31) begin
                        v_q.scroll.coarse_y <= 5'd0;  // attribute rows, no flip
                    end else begin
                        v_q.scroll.coarse_y <= v_q.scroll.coarse_y + 5'd1;
                    end
                end
                v_q.scroll.fine_y <= v_q.scroll.fine_y + 3'd1;
            end
            if (step_i.copy_x) begin
                v_q.scroll.coarse_x <= t_q.scroll.coarse_x;
                v_q.scroll.nt[0]    <= t_q.scroll.nt[0];
            end
            if (step_i.copy_y) begin
                v_q.scroll.fine_y   <= t_q.scroll.fine_y;
                v_q.scroll.coarse_y <= t_q.scroll.coarse_y;
                v_q.scroll.nt[1]    <= t_q.scroll.nt[1];
            end

            // vram still addressed by the old v here
            if (data_rd_q) begin
                rd_buf_q <= vram_rdata_i;
            end
            if (inc_v) begin
                v_q <= v_inc;
            end

            if (rd_edge) begin
                case (cpu_i.addr)
                    PPUSTATUS: begin
                        io_latch_q <= status;
                        vbl_occ_q  <= 1'b0;
                        w_q        <= 1'b0;
                    end
                    PPUDATA: begin
                        // palette bypasses the buffer
                        io_latch_q <= in_pal ? pal_rdata_i : rd_buf_q;
                        data_rd_q  <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end

            if (wr_edge) begin
                io_latch_q <= cpu_i.wdata;
                case (cpu_i.addr)
                    PPUCTRL: begin
                        ctrl_q          <= ppu_ctrl_t'(cpu_i.wdata);
                        t_q.scroll.nt   <= cpu_i.wdata[1:0];
                    end
                    PPUMASK: mask_q <= ppu_mask_t'(cpu_i.wdata);
                    PPUSCROLL: begin
                        if (!w_q) begin
                            t_q.scroll.coarse_x <= cpu_i.wdata[7:3];
                            fine_x_q            <= cpu_i.wdata[2:0];
                        end else begin
                            t_q.scroll.coarse_y <= cpu_i.wdata[7:3];
                            t_q.scroll.fine_y   <= cpu_i.wdata[2:0];
                        end
                        w_q <= ~w_q;
                    end
                    PPUADDR: begin
                        if (!w_q) begin
                            t_q.addr.spare       <= 1'b0;
                            t_q.addr.vaddr[13:8] <= cpu_i.wdata[5:0];
                        end else begin
                            t_q.addr.vaddr[7:0] <= cpu_i.wdata;
                            v_q                 <= {t_q[14:8], cpu_i.wdata};
                        end
                        w_q <= ~w_q;
                    end
                    PPUDATA: begin
                        vram_wr_q <= ~in_pal;
                        pal_wr_q  <= in_pal;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // fetches own the bus, otherwise v
    assign vram_addr_o  = (fetch_i != FETCH_NONE) ? fetch_addr_i : v_q.addr.vaddr;
    assign vram_wdata_o = io_latch_q;
    assign vram_wr_o    = vram_wr_q;
    assign pal_wr_o     = pal_wr_q;
    assign pal_sel_o    = in_pal;  // v points into the palette range
    assign cpu_rdata_o  = io_latch_q;

    assign v_o      = v_q;
    assign fine_x_o = fine_x_q;
    assign ctrl_o   = ctrl_q;
    assign mask_o   = mask_q;
    assign nmi_o    = vbl_flag & ctrl_q.nmi_en;

endmodule

/* verilog/ppu_pkg.sv */
package ppu_pkg;

    // cpu register offsets
    typedef enum logic [2:0] {
        PPUCTRL   = 3'd0,
        PPUMASK   = 3'd1,
        PPUSTATUS = 3'd2,
        OAMADDR   = 3'd3,
        OAMDATA   = 3'd4,
        PPUSCROLL = 3'd5,
        PPUADDR   = 3'd6,
        PPUDATA   = 3'd7
    } reg_addr_e;

    // v/t as seen by the renderer: yyy NN YYYYY XXXXX
    typedef struct packed {
        logic [2:0] fine_y;
        logic [1:0] nt;
        logic [4:0] coarse_y;
        logic [4:0] coarse_x;
    } loopy_scroll_t;

    // v/t as seen by the cpu data port
    typedef struct packed {
        logic        spare;
        logic [13:0] vaddr;
    } loopy_addr_t;

    typedef union packed {
        loopy_scroll_t scroll;
        loopy_addr_t   addr;
    } loopy_t;

    typedef struct packed {
        logic       nmi_en;
        logic       unused;   // master/slave select, no effect here
        logic       sp_size;
        logic       bg_table;
        logic       sp_table;
        logic       inc32;
        logic [1:0] base_nt;
    } ppu_ctrl_t;

    typedef struct packed {
        logic emph_b;
        logic emph_g;
        logic emph_r;
        logic sp_en;
        logic bg_en;
        logic sp_left;
        logic bg_left;
        logic grey;
    } ppu_mask_t;

    typedef enum logic [1:0] {
        FETCH_NONE,
        FETCH_NT,
        FETCH_AT,
        FETCH_PT
    } fetch_e;

    typedef struct packed {
        logic inc_x;
        logic inc_y;
        logic copy_x;
        logic copy_y;
    } scroll_step_t;

    typedef struct packed {
        logic       cs;
        logic       rw;       // 1 = read
        reg_addr_e  addr;
        logic [7:0] wdata;
    } cpu_bus_t;

    localparam int DOTS_PER_LINE   = 341;
    localparam int LINES_PER_FRAME = 262;
    localparam int VBLANK_LINE     = 241;
    localparam logic [7:0] PIXEL_BLACK = 8'h3f;

endpackage
